/* include/noc_cfg.svh */
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Traffic generator sizing

// Number of network ports, one packet source per port
`define NOC_PORTS 4

// Bits needed for a destination or source index
`define NOC_DEST_W 2

// Entries in each source queue
`define NOC_FIFO_DEPTH 8

// Per-port LFSR start values are derived from this constant
// Port number gets mixed in so every source runs its own sequence
`define NOC_SEED_BASE 32'hace1_2d5b

// Keep NOC_DEST_W at clog2 of NOC_PORTS
// NOC_PORTS must be at least 2 for the skip-self mapping

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the traffic generator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module traffic_gen_tb \
  -o traffic_gen_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# Keep running past assertion errors so the summary is printed
./obj_dir/traffic_gen_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** PASS **' "$LOG"; then
  echo "result: passed"
  exit 0
fi
echo "result: failed"
exit 1

/* sources.f */
+incdir+include
verilog/noc_pkg.sv
verilog/traffic_ctrl.sv
verilog/packet_fifo.sv
verilog/packet_source.sv
verilog/link_arbiter.sv
verilog/traffic_gen_top.sv
tests/traffic_gen_properties.sv
tests/traffic_gen_tb.sv

/* tests/traffic_gen_properties.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module traffic_gen_properties
(
  input logic                  clk,
  input logic                  rst,
  input noc_pkg::packet_t      link_out,
  input logic                  link_ready,
  input logic [`NOC_PORTS-1:0] fifo_error
);

  int assert_fails = 0;   // Count of failed assertions

  // Offered packet holds until the link takes it
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (link_out.valid && !link_ready) |=> $stable(link_out))
  else
  begin
    $error("link_out changed while valid and not accepted");
    assert_fails++;
  end

  // Nothing offered and no overflow flagged while in reset
  quiet_in_reset: assert property (@(posedge clk)
    rst |-> (!link_out.valid && (fifo_error == '0)))
  else
  begin
    $error("link valid or overflow flag seen during reset");
    assert_fails++;
  end

  // Overflow flags are sticky
  sticky_errors: assert property (@(posedge clk) disable iff (rst)
    ((~fifo_error & $past(fifo_error)) == '0))
  else
  begin
    $error("an overflow flag fell without reset");
    assert_fails++;
  end

endmodule

/* tests/traffic_gen_tb.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module traffic_gen_tb;

  localparam int dw           = `NOC_DEST_W;
  localparam int idle_cycles  = 200;   // Rate zero window
  localparam int run_cycles   = 400;   // Generation window per traffic phase
  localparam int fill_cycles  = 200;   // Back-pressure window
  localparam int quiet_cycles = 40;    // Link idle this long means drained
  localparam int drain_bound  = 150;   // Worst drain of 33 queued packets plus idle tail
  localparam int watchdog_cycles = 3 + idle_cycles + 3 * run_cycles + fill_cycles
                                   + 4 * drain_bound + 500;

  logic                  clk;
  logic                  rst;
  noc_pkg::gen_cfg_t     cfg_in;
  logic                  cfg_load;
  logic                  run;
  logic                  link_ready;
  noc_pkg::packet_t      link_out;
  logic [`NOC_PORTS-1:0] fifo_error;

  noc_pkg::gen_cfg_t     cur_cfg;                 // Config behind packets in flight
  string                 test_name;
  logic [`NOC_PORTS-1:0] err_expect;              // Overflow flags expected at transfers
  logic [31:0]           last_stamp [`NOC_PORTS];
  bit                    seen [`NOC_PORTS];
  int                    ready_mode;              // 0 low, 1 high, 2 random
  integer                seed;
  int                    xfer_count;
  int                    pkt_errors, flag_errors, count_errors, other_errors, total_errors;

  traffic_gen_top dut0
  (
    .clk(clk), .rst(rst),
    .cfg_in(cfg_in), .cfg_load(cfg_load), .run(run),
    .link_ready(link_ready), .link_out(link_out), .fifo_error(fifo_error)
  );

  bind traffic_gen_top traffic_gen_properties u_props
  (
    .clk(clk), .rst(rst), .link_out(link_out), .link_ready(link_ready),
    .fifo_error(fifo_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Network side that plays the router accepting packets
  initial
  begin
    int mode_now;
    link_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      mode_now = ready_mode;                        // Settled since last cycle
      #2;
      if (mode_now == 2)
        link_ready = (($random(seed) & 3) != 0);    // Ready three cycles in four
      else
        link_ready = (mode_now == 1);
    end
  end

  // Legal fields for a packet under a given config
  function automatic bit packet_legal(input noc_pkg::packet_t p, input noc_pkg::gen_cfg_t c);
    bit uni_ok;
    int hot;
    uni_ok = (int'(p.dest) < `NOC_PORTS) && (p.dest != p.source);   // Never to itself
    hot    = int'(c.hotspot_node);
    if (hot == int'(p.source))
      hot = (hot + 1) % `NOC_PORTS;                 // Hotspot source aims one further
    if (p.data < c.warmup)
      return 1'b0;
    case (c.mode)
      noc_pkg::MODE_HOTSPOT: return uni_ok || (int'(p.dest) == hot);
      noc_pkg::MODE_STREAM:
        return (p.source == c.stream_src) ? (p.dest == c.stream_dst) : uni_ok;
      default: return uni_ok;
    endcase
  endfunction

  function automatic noc_pkg::gen_cfg_t make_cfg(input noc_pkg::traffic_mode_e mode,
    input logic [31:0] rate, input logic [31:0] srate, input int hot, input int ssrc,
    input int sdst, input logic [31:0] warmup);
    noc_pkg::gen_cfg_t c;
    c.mode         = mode;
    c.rate         = rate;
    c.stream_rate  = srate;
    c.hotspot_node = dw'(hot);
    c.stream_src   = dw'(ssrc);
    c.stream_dst   = dw'(sdst);
    c.warmup       = warmup;
    return c;
  endfunction

  task automatic check_packet(input string name, input noc_pkg::packet_t p);
    int src;
    src = int'(p.source);
    if (!packet_legal(p, cur_cfg))
    begin
      pkt_errors++;
      $display("error %s: expected legal packet, actual dest %0d source %0d stamp %0d",
               name, p.dest, p.source, p.data);
    end
    if (seen[src] && (p.data <= last_stamp[src]))
    begin
      pkt_errors++;
      $display("error %s: expected stamp above %0d from source %0d, actual %0d",
               name, last_stamp[src], src, p.data);
    end
    seen[src]       = 1'b1;
    last_stamp[src] = p.data;
  endtask

  task automatic check_errors(input string name, input logic [`NOC_PORTS-1:0] exp,
                              input logic [`NOC_PORTS-1:0] act);
    if (act !== exp)
    begin
      flag_errors++;
      $display("error %s: expected fifo_error %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      count_errors++;
      $display("error %s: expected %0d transfers, actual %0d", name, exp, act);
    end
  endtask

  // Compare process runs at the falling edge where the handshake is settled
  always @(negedge clk)
  begin
    if (!rst && link_out.valid && link_ready)
    begin
      xfer_count++;
      check_packet(test_name, link_out);
      check_errors(test_name, err_expect, fifo_error);
    end
  end

  task automatic step(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic load_cfg(input noc_pkg::gen_cfg_t c);
    cfg_in   = c;
    cfg_load = 1'b1;
    cur_cfg  = c;
    step(1);
    cfg_load = 1'b0;
  endtask

  // Stop generating and wait until the link has been idle a while
  task automatic drain();
    int idle;
    idle = 0;
    run  = 1'b0;
    while (idle < quiet_cycles)
    begin
      step(1);
      if (link_out.valid)
        idle = 0;
      else
        idle++;
    end
  endtask

  task automatic run_phase(input string name, input int rmode, input noc_pkg::gen_cfg_t c);
    test_name  = name;
    xfer_count = 0;
    ready_mode = rmode;
    load_cfg(c);
    run = 1'b1;
    step(run_cycles);
    drain();
    if (xfer_count == 0)
    begin
      other_errors++;
      $display("no packets reached the link during the %s phase", name);
    end
  endtask

  initial
  begin
    #(watchdog_cycles * 20);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    rst        = 1'b1;
    cfg_in     = '0;
    cfg_load   = 1'b0;
    run        = 1'b0;
    ready_mode = 1;
    seed       = 32'hd6bb;
    cur_cfg    = '0;
    test_name  = "reset";
    err_expect = '0;
    seen       = '{default: 1'b0};
    last_stamp = '{default: 32'd0};
    xfer_count = 0;
    pkt_errors = 0;
    flag_errors  = 0;
    count_errors = 0;
    other_errors = 0;
    step(3);
    rst = 1'b0;

    // Rate zero keeps every source silent
    test_name = "idle";
    load_cfg(make_cfg(noc_pkg::MODE_UNIFORM, 32'd0, 32'd0, 0, 0, 1, 32'd0));
    run = 1'b1;
    step(idle_cycles);
    check_count("idle", 0, xfer_count);
    check_errors("idle", '0, fifo_error);
    run = 1'b0;

    run_phase("uniform", 1, make_cfg(noc_pkg::MODE_UNIFORM, 32'h2000_0000, 32'd0,
                                     0, 0, 1, 32'd0));
    // Warm-up ends about 100 cycles into the phase
    run_phase("hotspot", 2, make_cfg(noc_pkg::MODE_HOTSPOT, 32'h2000_0000, 32'd0,
                                     1, 0, 1, 32'($time / 20) + 32'd100));
    run_phase("stream", 2, make_cfg(noc_pkg::MODE_STREAM, 32'h1000_0000, 32'h4000_0000,
                                    0, 2, 0, 32'd0));

    // Link stalled so the queues fill and every port overflows
    test_name  = "backpressure";
    xfer_count = 0;
    ready_mode = 0;
    load_cfg(make_cfg(noc_pkg::MODE_UNIFORM, 32'h8000_0000, 32'd0, 0, 0, 1, 32'd0));
    run = 1'b1;
    step(fill_cycles);
    check_count("backpressure", 0, xfer_count);
    check_errors("backpressure", '1, fifo_error);
    err_expect = '1;
    run = 1'b0;
    step(5);
    ready_mode = 1;
    drain();
    // Every full queue plus the held output register
    check_count("backpressure", `NOC_PORTS * `NOC_FIFO_DEPTH + 1, xfer_count);
    check_errors("backpressure", '1, fifo_error);

    total_errors = pkt_errors + flag_errors + count_errors + other_errors
                   + dut0.u_props.assert_fails;
    $display("summary: %0d packet errors, %0d flag errors, %0d count errors, %0d other, %s",
             pkt_errors, flag_errors, count_errors, other_errors,
             $sformatf("%0d assertion", dut0.u_props.assert_fails));
    if (total_errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog/link_arbiter.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module link_arbiter
(
  input  logic                  clk,
  input  logic                  rst,
  input  noc_pkg::packet_t      heads [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] pop,
  output noc_pkg::packet_t      link_out,
  input  logic                  link_ready
);

  localparam int dw = `NOC_DEST_W;

  logic          link_free;   // Output register empty or being taken
  logic          found;
  logic [dw-1:0] last_q;      // Last granted port
  logic [dw-1:0] grant, cand;

  assign link_free = !link_out.valid || link_ready;

  // Round robin search starting after the last grant
  always_comb
  begin
    found = 1'b0;
    grant = last_q;
    cand  = last_q;
    for (int k = 1; k <= `NOC_PORTS; k++)
    begin
      cand = dw'((int'(last_q) + k) % `NOC_PORTS);
      if (!found && heads[cand].valid)
      begin
        found = 1'b1;
        grant = cand;
      end
    end
    pop = '0;
    if (link_free && found)
      pop[grant] = 1'b1;     // Pop in the cycle the head is loaded
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      link_out <= '0;
      last_q   <= dw'(`NOC_PORTS - 1);   // Port 0 wins first
    end
    else if (link_free)
    begin
      if (found)
      begin
        link_out <= heads[grant];
        last_q   <= grant;
      end
      else
        link_out.valid <= 1'b0;       // Transfer done, nothing waiting
    end
    // Not free means held until link_ready
  end

endmodule

/* verilog/noc_pkg.sv */
`include "noc_cfg.svh"

package noc_pkg;

  // Traffic pattern select
  typedef enum logic [1:0] {
    MODE_UNIFORM = 2'd0,  // Random destinations, never self
    MODE_HOTSPOT = 2'd1,  // Share of traffic aimed at one node
    MODE_STREAM  = 2'd2   // One fixed source to destination flow
  } traffic_mode_e;

  // Traffic configuration loaded through the config port
  typedef struct packed {
    traffic_mode_e               mode;
    logic [31:0]                 rate;          // LFSR threshold for normal ports
    logic [31:0]                 stream_rate;   // LFSR threshold for stream source
    logic [`NOC_DEST_W-1:0]      hotspot_node;
    logic [`NOC_DEST_W-1:0]      stream_src;
    logic [`NOC_DEST_W-1:0]      stream_dst;
    logic [31:0]                 warmup;        // No generation before this time
  } gen_cfg_t;

  // Queued packet, only raw destination plus creation time
  typedef struct packed {
    logic [`NOC_DEST_W-1:0] raw_dest;  // 0 to NOC_PORTS-2, self skipped at head
    logic [31:0]            stamp;
  } fifo_entry_t;

  // Packet as seen on the link
  typedef struct packed {
    logic                   valid;
    logic [`NOC_DEST_W-1:0] dest;
    logic [`NOC_DEST_W-1:0] source;
    logic [31:0]            data;   // Timestamp of creation
  } packet_t;

endpackage

/* verilog/packet_fifo.sv */
`timescale 1ns/1ns

module packet_fifo
#(
  parameter int depth = 8
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  noc_pkg::fifo_entry_t  din,
  input  logic                  wr_en,
  input  logic                  rd_en,
  output noc_pkg::fifo_entry_t  dout,
  output logic                  full,
  output logic                  empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  noc_pkg::fifo_entry_t mem [depth];
  logic [ptr_w-1:0]     wr_ptr, rd_ptr;
  logic [cnt_w-1:0]     count;
  logic                 do_wr, do_rd;

  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;    // Write into a full queue is dropped
  assign do_rd = rd_en && !empty;
  assign dout  = mem[rd_ptr];       // Show-ahead head entry

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      if (do_rd)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;                    // Both at once keeps level
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= din;
  end

endmodule

/* verilog/packet_source.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module packet_source
#(
  parameter int port_no = 0
)
(
  input  logic               clk,
  input  logic               rst,
  input  noc_pkg::gen_cfg_t  cfg,
  input  logic [31:0]        timestamp,
  input  logic               gen_en,
  input  logic               pop,
  output noc_pkg::packet_t   head,
  output logic               fifo_full,
  output logic               gen_write
);

  localparam int               dw      = `NOC_DEST_W;
  localparam logic [dw-1:0]    port_id = dw'(port_no);
  localparam logic [31:0]      seed    = (`NOC_SEED_BASE * 32'(port_no + 1)) | 32'd1;

  logic [31:0]          lfsr;
  logic [31:0]          threshold;
  logic [dw-1:0]        uni_raw, raw_sel, hot_dst;
  logic                 hot_hit, want;
  noc_pkg::fifo_entry_t entry_q, fifo_dout;
  logic                 fifo_empty;

  // Maps a destination back to its raw index before the skip-self step
  function automatic logic [dw-1:0] to_raw(input logic [dw-1:0] d);
    return (d > port_id) ? d - 1'b1 : d;
  endfunction

  // Pattern rules
  always_comb
  begin
    uni_raw   = dw'(lfsr[15:0] % 16'(`NOC_PORTS - 1));   // 0 to NOC_PORTS-2
    hot_hit   = (lfsr[18:16] == 3'd1) || (lfsr[18:16] == 3'd4);  // 2 of 8 states
    hot_dst   = (cfg.hotspot_node == port_id) ?
                dw'((int'(cfg.hotspot_node) + 1) % `NOC_PORTS) : cfg.hotspot_node;
    threshold = cfg.rate;
    raw_sel   = uni_raw;
    case (cfg.mode)
      noc_pkg::MODE_HOTSPOT:
      begin
        if (hot_hit)
          raw_sel = to_raw(hot_dst);
      end
      noc_pkg::MODE_STREAM:
      begin
        if (cfg.stream_src == port_id)
        begin
          threshold = cfg.stream_rate;     // Stream source has its own rate
          raw_sel   = to_raw(cfg.stream_dst);
        end
      end
      default: ;                           // Uniform
    endcase
    want = gen_en && (lfsr < threshold);
  end

  // LFSR with taps 32 22 2 1 and the registered write request
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      lfsr      <= seed;
      gen_write <= 1'b0;
    end
    else
    begin
      lfsr      <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      gen_write <= want;
    end
  end

  always_ff @(posedge clk)
  begin
    entry_q <= '{raw_dest: raw_sel, stamp: timestamp};  // Stamped at decision time
  end

  packet_fifo #(.depth(`NOC_FIFO_DEPTH)) u_fifo
  (
    .clk   (clk),
    .rst   (rst),
    .din   (entry_q),
    .wr_en (gen_write),
    .rd_en (pop),
    .dout  (fifo_dout),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  // Full packet built from the queue head
  always_comb
  begin
    head.valid  = !fifo_empty;
    head.dest   = (fifo_dout.raw_dest >= port_id) ? fifo_dout.raw_dest + 1'b1
                                                  : fifo_dout.raw_dest;  // Skip self
    head.source = port_id;
    head.data   = fifo_dout.stamp;
  end

endmodule

/* verilog/traffic_ctrl.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module traffic_ctrl
(
  input  logic                    clk,
  input  logic                    rst,
  input  noc_pkg::gen_cfg_t       cfg_in,
  input  logic                    cfg_load,
  input  logic                    run,
  input  logic [`NOC_PORTS-1:0]   fifo_full,
  input  logic [`NOC_PORTS-1:0]   gen_write,
  output noc_pkg::gen_cfg_t       cfg,
  output logic [31:0]             timestamp,
  output logic                    gen_en,
  output logic [`NOC_PORTS-1:0]   fifo_error
);

  noc_pkg::gen_cfg_t cfg_next;  // Configuration valid from next cycle on
  logic              warm;      // Warm-up period is over

  // New config and its warm-up gate apply together
  always_comb
  begin
    if (cfg_load)
    begin
      cfg_next = cfg_in;
    end
    else
    begin
      cfg_next = cfg;
    end
  end

  // Time after this edge is timestamp+1, so the gate stays safe
  assign warm = (timestamp >= cfg_next.warmup);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cfg        <= '0;           // Uniform mode with zero rate
      timestamp  <= '0;
      gen_en     <= 1'b0;
      fifo_error <= '0;
    end
    else
    begin
      cfg       <= cfg_next;
      timestamp <= timestamp + 32'd1;   // Free running global time
      gen_en    <= run && warm;
      // Sticky overflow, a write that met a full queue is lost
      fifo_error <= fifo_error | (gen_write & fifo_full);
    end
  end

  // Overflow flags only ever rise here
  // Cleared by rst alone

endmodule

/* verilog/traffic_gen_top.sv */
`timescale 1ns/1ns
`include "noc_cfg.svh"

module traffic_gen_top
(
  input  logic                  clk,
  input  logic                  rst,
  input  noc_pkg::gen_cfg_t     cfg_in,
  input  logic                  cfg_load,
  input  logic                  run,
  input  logic                  link_ready,
  output noc_pkg::packet_t      link_out,
  output logic [`NOC_PORTS-1:0] fifo_error
);

  noc_pkg::gen_cfg_t     cfg;
  logic [31:0]           timestamp;
  logic                  gen_en;
  logic [`NOC_PORTS-1:0] fifo_full, gen_write, pop;
  noc_pkg::packet_t      heads [`NOC_PORTS];   // One queue head per source

  traffic_ctrl u_ctrl
  (
    .clk(clk), .rst(rst),
    .cfg_in(cfg_in), .cfg_load(cfg_load), .run(run),
    .fifo_full(fifo_full), .gen_write(gen_write),
    .cfg(cfg), .timestamp(timestamp), .gen_en(gen_en), .fifo_error(fifo_error)
  );

  for (genvar i = 0; i < `NOC_PORTS; i++)
  begin : g_src
    packet_source #(.port_no(i)) u_src
    (
      .clk(clk), .rst(rst),
      .cfg(cfg), .timestamp(timestamp), .gen_en(gen_en), .pop(pop[i]),
      .head(heads[i]), .fifo_full(fifo_full[i]), .gen_write(gen_write[i])
    );
  end

  link_arbiter u_arb
  (
    .clk(clk), .rst(rst),
    .heads(heads), .pop(pop), .link_out(link_out), .link_ready(link_ready)
  );

endmodule
